// File: project.f
+incdir+src
src/axi_xbar_pkg.sv
src/axi_write_decoder.sv
src/axi_slave_mux_w.sv
src/axi_slave_mux_b.sv
src/axi_write_xbar.sv
testbench/tb_axi_write_xbar.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the write crossbar testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f project.f \
    --top-module tb_axi_write_xbar \
    -o tb_axi_write_xbar

./obj_dir/tb_axi_write_xbar | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: testbench/write_vectors.txt
# address data strobe expected_slave expected_resp, all hex
# slave f is an unmapped address, resp 0 okay, 2 slverr, 3 decerr
00000000 11111111 f 0 0
00000004 a5a5a5a5 3 0 0
00000ffc 22222222 c 0 0
00001000 33333333 f 1 0
00001ab0 44444444 1 1 0
00002000 55555555 f 2 0
00002ffc 66666666 8 2 0
00003000 77777777 f 3 0
00003ffc 88888888 f 3 2
00003ff8 99999999 6 3 0
00004000 aaaaaaaa f 4 0
00004ffc bbbbbbbb 5 4 0
00005000 cccccccc f f 3
00005ffc dddddddd f f 3
ffff0000 eeeeeeee f f 3
00000100 12345678 f 0 0
00003ffc 0badf00d f 3 2
00001ffc cafebabe f 1 0
80000000 deadbeef f f 3
00002010 01020304 e 2 0
00004800 0f0f0f0f f 4 0
00003ffc fedcba98 1 3 2
00000800 13579bdf f 0 0

// File: testbench/tb_axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_settings.svh"

// responder for one slave port with random stalls
module slave_model
    import axi_xbar_pkg::*;
#(
    parameter int INDEX = 0
) (
    input  wire logic     clk_i,
    input  wire logic     reset,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire aw_chan_t aw,
    input  wire logic     wvalid,
    output logic          wready,
    input  wire w_chan_t  w,
    output logic          bvalid,
    input  wire logic     bready,
    output resp_t         bresp,
    output int            write_count,
    output logic [31:0]   last_addr,
    output logic [2:0]    last_prot,
    output logic [31:0]   last_data,
    output logic [3:0]    last_strb,
    output int            timeout_count,
    output int            stray_count
);

    initial begin
        int delay;
        int n;
        awready       = 1'b0;
        wready        = 1'b0;
        bvalid        = 1'b0;
        bresp         = RESP_OKAY;
        write_count   = 0;
        last_addr     = '0;
        last_prot     = '0;
        last_data     = '0;
        last_strb     = '0;
        timeout_count = 0;
        stray_count   = 0;
        forever begin
            @(negedge clk_i);
            if (!reset && awvalid) begin
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                #1 awready = 1'b1;
                @(negedge clk_i);
                last_addr = aw.addr;
                last_prot = aw.prot;
                @(posedge clk_i);
                #1 awready = 1'b0;

                // data may already be waiting
                n = 0;
                @(negedge clk_i);
                while (!wvalid && n < 50) begin
                    @(negedge clk_i);
                    n++;
                end
                if (!wvalid) begin
                    $display("slave %0d timed out waiting for write data", INDEX);
                    timeout_count++;
                end else begin
                    delay = int'($urandom % 4);
                    repeat (delay) @(posedge clk_i);
                    @(posedge clk_i);
                    #1 wready = 1'b1;
                    @(negedge clk_i);
                    last_data = w.data;
                    last_strb = w.strb;
                    @(posedge clk_i);
                    #1 wready = 1'b0;

                    delay = int'($urandom % 4);
                    repeat (delay) @(posedge clk_i);
                    @(posedge clk_i);
                    #1;
                    bvalid = 1'b1;
                    // slave 3 flags its last word
                    if (INDEX == 3 && last_addr[`AXI_XBAR_REGION_BITS-1:0] == 12'hFFC) begin
                        bresp = RESP_SLVERR;
                    end else begin
                        bresp = RESP_OKAY;
                    end
                    n = 0;
                    @(negedge clk_i);
                    while (!bready && n < 50) begin
                        @(negedge clk_i);
                        n++;
                    end
                    if (!bready) begin
                        $display("slave %0d timed out waiting for bready", INDEX);
                        timeout_count++;
                    end
                    @(posedge clk_i);
                    #1 bvalid = 1'b0;
                    write_count++;
                end
            end else if (!reset && (wvalid || bready)) begin
                // not addressed, so data valid and bready must stay low
                $display("slave %0d saw write data or bready without an address", INDEX);
                stray_count++;
            end
        end
    end

endmodule

module tb_axi_write_xbar
    import axi_xbar_pkg::*;
;

    logic     clk_i;
    logic     reset;
    logic     awvalid;
    logic     awready;
    aw_chan_t aw;
    logic     wvalid;
    logic     wready;
    w_chan_t  w;
    logic     bvalid;
    logic     bready;
    resp_t    bresp;

    logic     sl_awvalid [5];
    logic     sl_awready [5];
    aw_chan_t sl_aw      [5];
    logic     sl_wvalid  [5];
    logic     sl_wready  [5];
    w_chan_t  sl_w       [5];
    logic     sl_bvalid  [5];
    logic     sl_bready  [5];
    resp_t    sl_bresp   [5];

    int          cnt         [5];
    logic [31:0] last_addr   [5];
    logic [2:0]  last_prot   [5];
    logic [31:0] last_data   [5];
    logic [3:0]  last_strb   [5];
    int          slave_tmo   [5];
    int          slave_stray [5];
    int          exp_count   [5];

    int pass_count;
    int fail_count;

    always #5 clk_i = ~clk_i;

    axi_write_xbar i_dut (
        .clk_i      (clk_i),
        .reset      (reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .s0_awvalid (sl_awvalid[0]), .s0_awready (sl_awready[0]), .s0_aw (sl_aw[0]),
        .s0_wvalid  (sl_wvalid[0]),  .s0_wready  (sl_wready[0]),  .s0_w  (sl_w[0]),
        .s0_bvalid  (sl_bvalid[0]),  .s0_bready  (sl_bready[0]),  .s0_bresp (sl_bresp[0]),
        .s1_awvalid (sl_awvalid[1]), .s1_awready (sl_awready[1]), .s1_aw (sl_aw[1]),
        .s1_wvalid  (sl_wvalid[1]),  .s1_wready  (sl_wready[1]),  .s1_w  (sl_w[1]),
        .s1_bvalid  (sl_bvalid[1]),  .s1_bready  (sl_bready[1]),  .s1_bresp (sl_bresp[1]),
        .s2_awvalid (sl_awvalid[2]), .s2_awready (sl_awready[2]), .s2_aw (sl_aw[2]),
        .s2_wvalid  (sl_wvalid[2]),  .s2_wready  (sl_wready[2]),  .s2_w  (sl_w[2]),
        .s2_bvalid  (sl_bvalid[2]),  .s2_bready  (sl_bready[2]),  .s2_bresp (sl_bresp[2]),
        .s3_awvalid (sl_awvalid[3]), .s3_awready (sl_awready[3]), .s3_aw (sl_aw[3]),
        .s3_wvalid  (sl_wvalid[3]),  .s3_wready  (sl_wready[3]),  .s3_w  (sl_w[3]),
        .s3_bvalid  (sl_bvalid[3]),  .s3_bready  (sl_bready[3]),  .s3_bresp (sl_bresp[3]),
        .s4_awvalid (sl_awvalid[4]), .s4_awready (sl_awready[4]), .s4_aw (sl_aw[4]),
        .s4_wvalid  (sl_wvalid[4]),  .s4_wready  (sl_wready[4]),  .s4_w  (sl_w[4]),
        .s4_bvalid  (sl_bvalid[4]),  .s4_bready  (sl_bready[4]),  .s4_bresp (sl_bresp[4])
    );

    for (genvar k = 0; k < 5; k++) begin : g_slave
        slave_model #(.INDEX(k)) i_slave (
            .clk_i         (clk_i),
            .reset         (reset),
            .awvalid       (sl_awvalid[k]),
            .awready       (sl_awready[k]),
            .aw            (sl_aw[k]),
            .wvalid        (sl_wvalid[k]),
            .wready        (sl_wready[k]),
            .w             (sl_w[k]),
            .bvalid        (sl_bvalid[k]),
            .bready        (sl_bready[k]),
            .bresp         (sl_bresp[k]),
            .write_count   (cnt[k]),
            .last_addr     (last_addr[k]),
            .last_prot     (last_prot[k]),
            .last_data     (last_data[k]),
            .last_strb     (last_strb[k]),
            .timeout_count (slave_tmo[k]),
            .stray_count   (slave_stray[k])
        );
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic finish_run();
        int total_fail;
        total_fail = fail_count;
        for (int j = 0; j < 5; j++) begin
            total_fail += slave_tmo[j] + slave_stray[j];
        end
        $display("passed %0d, failed %0d", pass_count, total_fail);
        if (total_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // one full write through the master port, returns the response
    task automatic master_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input logic [2:0] prot,
                                output resp_t got, output bit ok);
        int n;
        int delay;
        ok = 1'b1;
        got = RESP_OKAY;
        @(posedge clk_i);
        #1;
        awvalid = 1'b1;
        aw      = '{addr: addr, prot: prot};
        // data offered before the address is taken
        wvalid  = 1'b1;
        w       = '{data: data, strb: strb};
        n = 0;
        @(negedge clk_i);
        while (!awready && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (!awready) begin
            $display("timeout waiting for awready at address 0x%08h", addr);
            ok = 1'b0;
            return;
        end
        @(posedge clk_i);
        #1 awvalid = 1'b0;
        n = 0;
        @(negedge clk_i);
        while (!wready && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (!wready) begin
            $display("timeout waiting for wready at address 0x%08h", addr);
            ok = 1'b0;
            return;
        end
        @(posedge clk_i);
        #1 wvalid = 1'b0;
        delay = int'($urandom % 4);
        repeat (delay) @(posedge clk_i);
        #1 bready = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (!bvalid && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (!bvalid) begin
            $display("timeout waiting for bvalid at address 0x%08h", addr);
            ok = 1'b0;
            return;
        end
        got = bresp;
        @(posedge clk_i);
        #1 bready = 1'b0;
    endtask

    initial begin
        int          fd;
        int          vec_idx;
        int          fails_before;
        string       line;
        logic [31:0] v_addr;
        logic [31:0] v_data;
        logic [31:0] v_strb;
        logic [31:0] v_slave;
        logic [31:0] v_resp;
        logic [2:0]  v_prot;
        resp_t       got;
        bit          ok;
        bit          aborted;

        void'($urandom(70));
        pass_count = 0;
        fail_count = 0;
        aborted    = 1'b0;
        clk_i      = 1'b0;
        reset      = 1'b1;
        awvalid    = 1'b0;
        aw         = '0;
        wvalid     = 1'b0;
        w          = '0;
        bready     = 1'b0;
        for (int j = 0; j < 5; j++) begin
            exp_count[j] = 0;
        end

        repeat (2) @(posedge clk_i);
        #1 reset = 1'b0;

        // idle outputs right after reset
        @(negedge clk_i);
        for (int j = 0; j < 5; j++) begin
            check_value($sformatf("s%0d_awvalid", j), 32'(sl_awvalid[j]), 32'h0);
            check_value($sformatf("s%0d_wvalid", j), 32'(sl_wvalid[j]), 32'h0);
        end
        check_value("bvalid", 32'(bvalid), 32'h0);
        check_value("wready", 32'(wready), 32'h0);
        $display("reset state: %s", (fail_count == 0) ? "ok" : "wrong");

        fd = $fopen("testbench/write_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/write_vectors.txt");
            fail_count++;
        end else begin
            vec_idx = 0;
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == 8'h23) begin
                    continue;
                end
                if ($sscanf(line, "%h %h %h %h %h", v_addr, v_data, v_strb, v_slave,
                            v_resp) != 5) begin
                    $display("malformed vector line: %s", line);
                    fail_count++;
                    continue;
                end
                fails_before = fail_count;
                // protection bits vary per write
                v_prot = 3'(vec_idx);
                master_write(v_addr, v_data, v_strb[3:0], v_prot, got, ok);
                if (!ok) begin
                    fail_count++;
                    aborted = 1'b1;
                end else begin
                    if (v_slave < 5) begin
                        exp_count[v_slave] = exp_count[v_slave] + 1;
                    end
                    // let the slave model close its count
                    @(negedge clk_i);
                    check_value("bresp", 32'(got), v_resp);
                    if (v_slave < 5) begin
                        check_value("slave_addr", last_addr[v_slave], v_addr);
                        check_value("slave_prot", 32'(last_prot[v_slave]), 32'(v_prot));
                        check_value("slave_data", last_data[v_slave], v_data);
                        check_value("slave_strb", 32'(last_strb[v_slave]), v_strb);
                    end
                    for (int j = 0; j < 5; j++) begin
                        check_value($sformatf("s%0d_count", j), 32'(cnt[j]),
                                    32'(exp_count[j]));
                    end
                    $display("vector %0d addr 0x%08h slave %0d: %s", vec_idx, v_addr,
                             v_slave, (fail_count == fails_before) ? "ok" : "mismatch");
                    vec_idx++;
                end
            end
            $fclose(fd);

            if (!aborted) begin
                // every write landed exactly once
                fails_before = fail_count;
                repeat (5) @(negedge clk_i);
                for (int j = 0; j < 5; j++) begin
                    check_value($sformatf("s%0d_final_count", j), 32'(cnt[j]),
                                32'(exp_count[j]));
                end
                $display("final counts: %s", (fail_count == fails_before) ? "ok" : "wrong");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: src/axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_settings.svh"

module axi_write_xbar
    import axi_xbar_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset,
    // master port
    input  wire logic     awvalid,
    output logic          awready,
    input  wire aw_chan_t aw,
    input  wire logic     wvalid,
    output logic          wready,
    input  wire w_chan_t  w,
    output logic          bvalid,
    input  wire logic     bready,
    output resp_t         bresp,
    // slave ports
    output logic          s0_awvalid,
    input  wire logic     s0_awready,
    output aw_chan_t      s0_aw,
    output logic          s0_wvalid,
    input  wire logic     s0_wready,
    output w_chan_t       s0_w,
    input  wire logic     s0_bvalid,
    output logic          s0_bready,
    input  wire resp_t    s0_bresp,
    output logic          s1_awvalid,
    input  wire logic     s1_awready,
    output aw_chan_t      s1_aw,
    output logic          s1_wvalid,
    input  wire logic     s1_wready,
    output w_chan_t       s1_w,
    input  wire logic     s1_bvalid,
    output logic          s1_bready,
    input  wire resp_t    s1_bresp,
    output logic          s2_awvalid,
    input  wire logic     s2_awready,
    output aw_chan_t      s2_aw,
    output logic          s2_wvalid,
    input  wire logic     s2_wready,
    output w_chan_t       s2_w,
    input  wire logic     s2_bvalid,
    output logic          s2_bready,
    input  wire resp_t    s2_bresp,
    output logic          s3_awvalid,
    input  wire logic     s3_awready,
    output aw_chan_t      s3_aw,
    output logic          s3_wvalid,
    input  wire logic     s3_wready,
    output w_chan_t       s3_w,
    input  wire logic     s3_bvalid,
    output logic          s3_bready,
    input  wire resp_t    s3_bresp,
    output logic          s4_awvalid,
    input  wire logic     s4_awready,
    output aw_chan_t      s4_aw,
    output logic          s4_wvalid,
    input  wire logic     s4_wready,
    output w_chan_t       s4_w,
    input  wire logic     s4_bvalid,
    output logic          s4_bready,
    input  wire resp_t    s4_bresp
);

    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_awvalid;
    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_awready;
    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_wvalid;
    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_wready;
    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_bvalid;
    logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_bready;
    resp_t [`AXI_XBAR_NUM_SLAVES-1:0] s_bresp;
    aw_chan_t                         s_aw;
    w_chan_t                          s_w;
    slave_sel_t                       s_wsel;
    logic                             err_wready;
    logic                             err_bvalid;
    resp_t                            err_bresp;

    // per-slave signals packed, slave 0 in bit 0
    assign s_awready = {s4_awready, s3_awready, s2_awready, s1_awready, s0_awready};
    assign s_wready  = {s4_wready, s3_wready, s2_wready, s1_wready, s0_wready};
    assign s_bvalid  = {s4_bvalid, s3_bvalid, s2_bvalid, s1_bvalid, s0_bvalid};
    assign s_bresp[0] = s0_bresp;
    assign s_bresp[1] = s1_bresp;
    assign s_bresp[2] = s2_bresp;
    assign s_bresp[3] = s3_bresp;
    assign s_bresp[4] = s4_bresp;

    assign {s4_awvalid, s3_awvalid, s2_awvalid, s1_awvalid, s0_awvalid} = s_awvalid;
    assign {s4_wvalid, s3_wvalid, s2_wvalid, s1_wvalid, s0_wvalid}      = s_wvalid;
    assign {s4_bready, s3_bready, s2_bready, s1_bready, s0_bready}      = s_bready;

    // address and data go to every slave
    assign s0_aw = s_aw;
    assign s1_aw = s_aw;
    assign s2_aw = s_aw;
    assign s3_aw = s_aw;
    assign s4_aw = s_aw;
    assign s0_w  = s_w;
    assign s1_w  = s_w;
    assign s2_w  = s_w;
    assign s3_w  = s_w;
    assign s4_w  = s_w;

    axi_write_decoder i_decoder (
        .clk_i      (clk_i),
        .reset      (reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .aw         (aw),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_aw       (s_aw),
        .s_wsel     (s_wsel),
        .err_wready (err_wready),
        .err_bvalid (err_bvalid),
        .err_bresp  (err_bresp)
    );

    axi_slave_mux_w i_mux_w (
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w),
        .s_wsel     (s_wsel),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_w        (s_w),
        .err_wready (err_wready)
    );

    axi_slave_mux_b i_mux_b (
        .s_wsel     (s_wsel),
        .s_bvalid   (s_bvalid),
        .s_bresp    (s_bresp),
        .s_bready   (s_bready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .err_bvalid (err_bvalid),
        .err_bresp  (err_bresp)
    );

endmodule

`default_nettype wire

// File: src/axi_slave_mux_b.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_settings.svh"

module axi_slave_mux_b
    import axi_xbar_pkg::*;
(
    input  wire slave_sel_t                       s_wsel,
    input  wire logic  [`AXI_XBAR_NUM_SLAVES-1:0] s_bvalid,
    input  wire resp_t [`AXI_XBAR_NUM_SLAVES-1:0] s_bresp,
    output logic       [`AXI_XBAR_NUM_SLAVES-1:0] s_bready,
    output logic                                  bvalid,
    output resp_t                                 bresp,
    input  wire logic                             bready,
    input  wire logic                             err_bvalid,
    input  wire resp_t                            err_bresp
);

    // response back to the master
    always_comb begin
        bvalid = 1'b0;
        bresp  = RESP_OKAY;
        if (s_wsel == SEL_NONE) begin
            bvalid = err_bvalid;
            bresp  = err_bresp;
        end else begin
            for (int i = 0; i < `AXI_XBAR_NUM_SLAVES; i++) begin
                if (s_wsel == slave_sel_t'(i)) begin
                    bvalid = s_bvalid[i];
                    bresp  = s_bresp[i];
                end
            end
        end
    end

    // unselected slaves see bready low and keep their response
    always_comb begin
        s_bready = '0;
        for (int i = 0; i < `AXI_XBAR_NUM_SLAVES; i++) begin
            if (s_wsel == slave_sel_t'(i)) begin
                s_bready[i] = bready;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/axi_slave_mux_w.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_settings.svh"

module axi_slave_mux_w
    import axi_xbar_pkg::*;
(
    input  wire logic                            wvalid,
    output logic                                 wready,
    input  wire w_chan_t                         w,
    input  wire slave_sel_t                      s_wsel,
    output logic     [`AXI_XBAR_NUM_SLAVES-1:0]  s_wvalid,
    input  wire logic [`AXI_XBAR_NUM_SLAVES-1:0] s_wready,
    output w_chan_t                              s_w,
    input  wire logic                            err_wready
);

    // ready from the selected slave
    always_comb begin
        case (s_wsel)
            4'h0: begin
                wready = s_wready[0];
            end
            4'h1: begin
                wready = s_wready[1];
            end
            4'h2: begin
                wready = s_wready[2];
            end
            4'h3: begin
                wready = s_wready[3];
            end
            4'h4: begin
                wready = s_wready[4];
            end
            SEL_NONE: begin
                // only high in WR_DATA for an unmapped write
                wready = err_wready;
            end
            default: begin
                wready = 1'b0;
            end
        endcase
    end

    // valid to one slave at most
    always_comb begin
        s_wvalid = '0;
        for (int i = 0; i < `AXI_XBAR_NUM_SLAVES; i++) begin
            if (s_wsel == slave_sel_t'(i)) begin
                s_wvalid[i] = wvalid;
            end
        end
    end

    // payload broadcast, qualified by valid
    assign s_w = w;

endmodule

`default_nettype wire

// File: src/axi_write_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_xbar_settings.svh"

module axi_write_decoder
    import axi_xbar_pkg::*;
(
    input  wire logic                            clk_i,
    input  wire logic                            reset,
    input  wire logic                            awvalid,
    output logic                                 awready,
    input  wire aw_chan_t                        aw,
    input  wire logic                            wvalid,
    input  wire logic                            wready,
    input  wire logic                            bvalid,
    input  wire logic                            bready,
    output logic     [`AXI_XBAR_NUM_SLAVES-1:0]  s_awvalid,
    input  wire logic [`AXI_XBAR_NUM_SLAVES-1:0] s_awready,
    output aw_chan_t                             s_aw,
    output slave_sel_t                           s_wsel,
    output logic                                 err_wready,
    output logic                                 err_bvalid,
    output resp_t                                err_bresp
);

    localparam int REGION_IDX_W = `AXI_XBAR_ADDR_WIDTH - `AXI_XBAR_REGION_BITS;

    wr_state_t                       state;
    logic [`AXI_XBAR_ADDR_WIDTH-1:0] addr_offset;
    logic [REGION_IDX_W-1:0]         region_idx;
    logic                            dec_hit;
    slave_sel_t                      dec_sel;

    // addresses below base wrap to a large offset and miss the map
    always_comb begin
        addr_offset = aw.addr - `AXI_XBAR_BASE;
        region_idx  = addr_offset[`AXI_XBAR_ADDR_WIDTH-1:`AXI_XBAR_REGION_BITS];
        dec_hit     = region_idx < REGION_IDX_W'(`AXI_XBAR_NUM_SLAVES);
        dec_sel     = dec_hit ? slave_sel_t'(region_idx) : SEL_NONE;
    end

    // aw routed only while idle
    always_comb begin
        s_awvalid = '0;
        awready   = 1'b0;
        if (state == WR_IDLE) begin
            if (!dec_hit) begin
                // unmapped, take the address here
                awready = 1'b1;
            end
            for (int i = 0; i < `AXI_XBAR_NUM_SLAVES; i++) begin
                if (dec_sel == slave_sel_t'(i)) begin
                    s_awvalid[i] = awvalid;
                    awready      = s_awready[i];
                end
            end
        end
    end

    assign s_aw = aw;

    // selection held through data and response
    always_ff @(posedge clk_i) begin
        if (reset) begin
            state  <= WR_IDLE;
            s_wsel <= SEL_NONE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (awvalid && awready) begin
                        state  <= WR_DATA;
                        s_wsel <= dec_sel;
                    end
                end
                WR_DATA: begin
                    if (wvalid && wready) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid && bready) begin
                        state  <= WR_IDLE;
                        s_wsel <= SEL_NONE;
                    end
                end
                default: begin
                    state  <= WR_IDLE;
                    s_wsel <= SEL_NONE;
                end
            endcase
        end
    end

    // error slave: swallow the data, then answer DECERR
    assign err_wready = (state == WR_DATA) && (s_wsel == SEL_NONE);
    assign err_bvalid = (state == WR_RESP) && (s_wsel == SEL_NONE);
    assign err_bresp  = RESP_DECERR;

endmodule

`default_nettype wire

// File: src/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

`include "axi_xbar_settings.svh"

    localparam int STRB_WIDTH = `AXI_XBAR_DATA_WIDTH / 8;

    // slave index, 0 to 4 are real slaves
    typedef logic [3:0] slave_sel_t;

    // no slave selected, decode error target
    localparam slave_sel_t SEL_NONE = 4'hF;

    typedef struct packed {
        logic [`AXI_XBAR_ADDR_WIDTH-1:0] addr;
        logic [2:0]                      prot;
    } aw_chan_t;

    typedef struct packed {
        logic [`AXI_XBAR_DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0]           strb;
    } w_chan_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // one write in flight at a time
    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_DATA = 2'b01,
        WR_RESP = 2'b10
    } wr_state_t;

endpackage

`default_nettype wire

// File: src/axi_xbar_settings.svh
`ifndef AXI_XBAR_SETTINGS_SVH
`define AXI_XBAR_SETTINGS_SVH

// slave ports on the write path
`define AXI_XBAR_NUM_SLAVES 5

// bus widths
`define AXI_XBAR_ADDR_WIDTH 32
`define AXI_XBAR_DATA_WIDTH 32

// log2 of one region, 4 KiB per slave
`define AXI_XBAR_REGION_BITS 12

// slave 0 starts here, slave i at base + i * region
`define AXI_XBAR_BASE 32'h0000_0000

`endif
